//--- positPkg.sv
// Constants cover posit16 with es = 1 only and the datapath widths follow from them
package positPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Format constants
    ////////////////////////////////////////////////////////////////////////////

    localparam int positWidth = 16;
    localparam int expWidth = 1;
    // Signed regime k plus its sign bit
    localparam int regimeWidth = $clog2(positWidth) + 1;
    // Combined scale k * 2^es + e
    localparam int scaleWidth = regimeWidth + expWidth;
    // Hidden one below a spare overflow bit
    localparam int mantWidth = positWidth;
    localparam int bodyWidth = positWidth - 1;
    // Extra low bits kept through alignment for rounding
    localparam int guardBits = 3;
    localparam int alignWidth = mantWidth + guardBits;
    localparam int pipeDepth = 3;

    // NaR is one followed by zeros
    localparam logic [positWidth-1:0] narPattern = {1'b1, {(positWidth-1){1'b0}}};

    // Special-case codes carried down the pipeline
    localparam int codeWidth = 3;
    localparam logic [codeWidth-1:0] codeNormal = 3'd0;
    localparam logic [codeWidth-1:0] codeNaR = 3'd1;
    localparam logic [codeWidth-1:0] codePassA = 3'd2;
    localparam logic [codeWidth-1:0] codePassB = 3'd3;
    localparam logic [codeWidth-1:0] codeZero = 3'd4;

    ////////////////////////////////////////////////////////////////////////////
    // Posit word, seen as a number or as sign and body
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic sign;
        logic [bodyWidth-1:0] body;
    } positFields;

    typedef union packed {
        logic signed [positWidth-1:0] value;
        positFields fields;
    } positWord;

endpackage

//--- leadingBitDetector.sv
// Normal position is the hidden-bit slot one below the top; an all-zero input gives zero
`timescale 1ns/1ps

module leadingBitDetector
(
    input  logic [positPkg::mantWidth-1:0] value,
    output logic signed [positPkg::regimeWidth-1:0] shift
);

    logic found;

    always_comb
    begin
        shift = '0;
        found = 1'b0;
        // Priority search from the top bit down
        // A one in the overflow slot reads as -1
        for (int i = positPkg::mantWidth - 1; i >= 0; i--)
        begin
            if (!found && value[i])
            begin
                shift = (positPkg::regimeWidth)'(positPkg::mantWidth - 2 - i);
                found = 1'b1;
            end
        end
    end

endmodule

//--- positDecoder.sv
// Purely combinational; fields of zero and NaR words are meaningless and only the flags count
`timescale 1ns/1ps

module positDecoder
(
    input  positPkg::positWord word,
    output logic sign,
    output logic signed [positPkg::regimeWidth-1:0] regime,
    output logic [positPkg::expWidth-1:0] exponent,
    output logic [positPkg::mantWidth-1:0] mantissa,
    output logic [positPkg::bodyWidth-1:0] body,
    output logic isNaR,
    output logic isZero
);

    logic regimeBit;
    logic runDone;
    logic [positPkg::regimeWidth-2:0] runLen;
    logic signed [positPkg::regimeWidth-1:0] runSigned;
    logic [positPkg::regimeWidth-1:0] restShift;
    logic [positPkg::bodyWidth-1:0] rest;

    always_comb
    begin
        sign = word.fields.sign;
        // Magnitude of the body
        // Negative words take the two's complement of the low bits
        body = sign ? -word.fields.body : word.fields.body;

        // Regime run length, counted from the top of the body
        regimeBit = body[positPkg::bodyWidth-1];
        runLen = (positPkg::regimeWidth-1)'(positPkg::bodyWidth);
        runDone = 1'b0;
        for (int i = positPkg::bodyWidth - 1; i >= 0; i--)
        begin
            if (!runDone && body[i] != regimeBit)
            begin
                runLen = (positPkg::regimeWidth-1)'(positPkg::bodyWidth - 1 - i);
                runDone = 1'b1;
            end
        end

        // Run of ones gives k = m - 1
        // Run of zeros gives k = -m
        runSigned = {1'b0, runLen};
        regime = regimeBit ? runSigned - 5'sd1 : -runSigned;

        // Drop run and terminator, exponent then sits on top
        restShift = {1'b0, runLen} + 5'd1;
        rest = body << restShift;
        exponent = rest[positPkg::bodyWidth-1 -: positPkg::expWidth];

        // Overflow bit clear, hidden one, then the fraction
        mantissa = {1'b0, 1'b1, rest[positPkg::bodyWidth-positPkg::expWidth-1:0]};

        isZero = (word.value == '0);
        isNaR = (word.value == positPkg::narPattern);
    end

endmodule

//--- positAddSub.sv
// Fixed to es = 1; one register stage on the inputs and zero or NaR operands are handled outside
`timescale 1ns/1ps

module positAddSub
(
    input  logic clk,
    input  logic rst,
    input  logic sign1,
    input  logic sign2,
    input  logic signed [positPkg::regimeWidth-1:0] regime1,
    input  logic signed [positPkg::regimeWidth-1:0] regime2,
    input  logic [positPkg::expWidth-1:0] exponent1,
    input  logic [positPkg::expWidth-1:0] exponent2,
    input  logic [positPkg::mantWidth-1:0] mantissa1,
    input  logic [positPkg::mantWidth-1:0] mantissa2,
    input  logic [positPkg::bodyWidth-1:0] body1,
    input  logic [positPkg::bodyWidth-1:0] body2,
    output logic [positPkg::mantWidth-1:0] sumMant,
    output logic signed [positPkg::scaleWidth-1:0] sumScale,
    output logic sumSign,
    output logic sumZero
);

    // Stage 2 operand registers
    logic regSign1, regSign2;
    logic signed [positPkg::scaleWidth-1:0] regScale1, regScale2;
    logic [positPkg::mantWidth-1:0] regMant1, regMant2;
    logic [positPkg::bodyWidth-1:0] regBody1, regBody2;

    // Large and small operand after the magnitude compare
    logic addOp;
    logic greater;
    logic signed [positPkg::scaleWidth-1:0] largeScale, smallScale;
    logic [positPkg::mantWidth-1:0] largeMant, smallMant;
    logic [positPkg::scaleWidth:0] scaleDiff;

    logic [positPkg::alignWidth-1:0] largeExt, smallExt;
    logic [positPkg::alignWidth-1:0] alignMask, alignedSmall;
    logic alignSticky;
    logic [positPkg::alignWidth-1:0] sumExt, normExt;
    logic mantOvf;
    logic [positPkg::mantWidth-1:0] lbdIn;
    logic signed [positPkg::regimeWidth-1:0] shift;

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2 register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            regSign1 <= 1'b0;
            regSign2 <= 1'b0;
            regScale1 <= '0;
            regScale2 <= '0;
            regMant1 <= '0;
            regMant2 <= '0;
            regBody1 <= '0;
            regBody2 <= '0;
        end
        else
        begin
            regSign1 <= sign1;
            regSign2 <= sign2;
            // Scale is k * 2^es + e, same as {k, e} for signed k
            regScale1 <= {regime1, exponent1};
            regScale2 <= {regime2, exponent2};
            regMant1 <= mantissa1;
            regMant2 <= mantissa2;
            regBody1 <= body1;
            regBody2 <= body2;
        end
    end

    leadingBitDetector i_leadingBitDetector
    (
        .value(lbdIn),
        .shift(shift)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Align, add, normalize
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        // Equal signs add, unequal signs subtract
        addOp = regSign1 ~^ regSign2;

        // Posit bodies order the same way as magnitudes
        greater = regBody1 > regBody2;
        sumSign = greater ? regSign1 : regSign2;
        largeScale = greater ? regScale1 : regScale2;
        smallScale = greater ? regScale2 : regScale1;
        largeMant = greater ? regMant1 : regMant2;
        smallMant = greater ? regMant2 : regMant1;

        // Never negative, up to twice maxpos scale
        scaleDiff = {largeScale[positPkg::scaleWidth-1], largeScale}
            - {smallScale[positPkg::scaleWidth-1], smallScale};

        largeExt = {largeMant, {positPkg::guardBits{1'b0}}};
        smallExt = {smallMant, {positPkg::guardBits{1'b0}}};

        // Bits shifted out jam into the lowest bit as sticky
        alignMask = ~({positPkg::alignWidth{1'b1}} << scaleDiff);
        alignSticky = |(smallExt & alignMask);
        alignedSmall = (smallExt >> scaleDiff) | {{(positPkg::alignWidth-1){1'b0}}, alignSticky};

        if (addOp)
            sumExt = largeExt + alignedSmall;
        else
            sumExt = largeExt - alignedSmall;

        mantOvf = sumExt[positPkg::alignWidth-1];
        sumZero = (sumExt == '0);

        // Overflow folds into the hidden slot so the detector sees zero shift
        lbdIn = {1'b0, sumExt[positPkg::alignWidth-1] | sumExt[positPkg::alignWidth-2],
            sumExt[positPkg::alignWidth-3:positPkg::guardBits]};

        if (mantOvf)
            normExt = {1'b0, sumExt[positPkg::alignWidth-1:2], |sumExt[1:0]};
        else
            normExt = sumExt << shift;

        // Hidden one on top, low guard bits squeezed into one sticky bit
        sumMant = {normExt[positPkg::alignWidth-2:positPkg::guardBits],
            |normExt[positPkg::guardBits-1:0]};

        // Larger operand scale, plus overflow, minus renormalization
        sumScale = largeScale + {{(positPkg::scaleWidth-1){1'b0}}, mantOvf}
            - {shift[positPkg::regimeWidth-1], shift};
    end

endmodule

//--- positEncoder.sv
// Expects the hidden one at the top of mant and a sticky LSB; never returns zero or NaR
`timescale 1ns/1ps

module positEncoder
(
    input  logic sign,
    input  logic signed [positPkg::scaleWidth-1:0] scale,
    input  logic [positPkg::mantWidth-1:0] mant,
    output positPkg::positWord word
);

    logic signed [positPkg::regimeWidth-1:0] k;
    logic [positPkg::expWidth-1:0] e;
    logic [positPkg::regimeWidth-1:0] runLen;
    logic [positPkg::regimeWidth-1:0] regLen;
    // Regime run, left aligned
    logic [2*positPkg::positWidth-1:0] regBits;
    // Regime, exponent and fraction in one frame
    logic [3*positPkg::positWidth-1:0] frame;
    logic [positPkg::bodyWidth-1:0] body;
    logic guard;
    logic sticky;
    logic roundUp;
    logic [positPkg::positWidth-1:0] rounded;
    logic [positPkg::bodyWidth-1:0] satBody;

    always_comb
    begin
        // Scale splits back into {k, e}
        k = scale[positPkg::scaleWidth-1:positPkg::expWidth];
        e = scale[positPkg::expWidth-1:0];

        if (k[positPkg::regimeWidth-1])
        begin
            // -k zeros then a one
            runLen = -k;
            regBits = {1'b1, {(2*positPkg::positWidth-1){1'b0}}} >> runLen;
        end
        else
        begin
            // k + 1 ones, terminating zero comes free
            runLen = k + 5'd1;
            regBits = ~({(2*positPkg::positWidth){1'b1}} >> runLen);
        end
        regLen = runLen + 5'd1;

        // Exponent and fraction follow the terminator
        frame = {regBits, {positPkg::positWidth{1'b0}}}
            | ({e, mant[positPkg::mantWidth-2:0],
                {(3*positPkg::positWidth-positPkg::expWidth-positPkg::mantWidth+1){1'b0}}}
                >> regLen);

        body = frame[3*positPkg::positWidth-1 -: positPkg::bodyWidth];
        guard = frame[3*positPkg::positWidth-1-positPkg::bodyWidth];
        sticky = |frame[3*positPkg::positWidth-2-positPkg::bodyWidth:0];

        // Nearest even on the bit string
        roundUp = guard & (sticky | body[0]);
        rounded = {1'b0, body} + {{positPkg::bodyWidth{1'b0}}, roundUp};

        // Clamp to maxpos or minpos
        if (rounded[positPkg::positWidth-1])
            satBody = {positPkg::bodyWidth{1'b1}};
        else if (rounded == '0)
            satBody = {{(positPkg::bodyWidth-1){1'b0}}, 1'b1};
        else
            satBody = rounded[positPkg::bodyWidth-1:0];

        // negative result is the two's complement word
        word.value = sign ? -{1'b0, satBody} : {1'b0, satBody};
    end

endmodule

//--- positAddControl.sv
// No back-pressure; a new operation may enter every cycle and leaves exactly three later
`timescale 1ns/1ps

module positAddControl
(
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  logic subtract,
    input  positPkg::positWord a,
    input  positPkg::positWord b,
    output positPkg::positWord opA,
    output positPkg::positWord opB,
    input  logic nar1,
    input  logic nar2,
    input  logic zero1,
    input  logic zero2,
    input  logic [positPkg::mantWidth-1:0] sumMant,
    input  logic signed [positPkg::scaleWidth-1:0] sumScale,
    input  logic sumSign,
    input  logic sumZero,
    output logic [positPkg::mantWidth-1:0] encMant,
    output logic signed [positPkg::scaleWidth-1:0] encScale,
    output logic encSign,
    input  positPkg::positWord encWord,
    output logic outValid,
    output positPkg::positWord result
);

    // One valid bit per stage, the last one is outValid
    logic [positPkg::pipeDepth:0] validPipe;
    logic [positPkg::codeWidth-1:0] specialCode, code2, code3;
    positPkg::positWord passWord2, passWord3;
    positPkg::positWord outWord;
    logic zero3;

    // Bypass decision from the decoder flags
    always_comb
    begin
        if (nar1 || nar2)
            specialCode = positPkg::codeNaR;
        else if (zero1 && zero2)
            specialCode = positPkg::codeZero;
        else if (zero2)
            specialCode = positPkg::codePassA;
        else if (zero1)
            specialCode = positPkg::codePassB;
        else
            specialCode = positPkg::codeNormal;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        // Stage 1 capture, subtrahend negated as an integer
        if (inValid)
        begin
            opA <= a;
            opB.value <= subtract ? -b.value : b.value;
        end
        // Stage 2, special case rides alongside the core register
        code2 <= specialCode;
        passWord2 <= (specialCode == positPkg::codePassA) ? opA : opB;
        // Stage 3
        code3 <= code2;
        passWord3 <= passWord2;
        encMant <= sumMant;
        encScale <= sumScale;
        encSign <= sumSign;
        zero3 <= sumZero;
    end

    // Final word choice
    always_comb
    begin
        case (code3)
            positPkg::codeNaR: outWord.value = positPkg::narPattern;
            positPkg::codeZero: outWord.value = '0;
            positPkg::codePassA, positPkg::codePassB: outWord = passWord3;
            default: outWord.value = zero3 ? '0 : encWord.value;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            validPipe <= '0;
            result <= '0;
        end
        else
        begin
            validPipe <= {validPipe[positPkg::pipeDepth-1:0], inValid};
            // Holds the last answer between operations
            if (validPipe[positPkg::pipeDepth-1])
                result <= outWord;
        end
    end

    assign outValid = validPipe[positPkg::pipeDepth];

endmodule

//--- positAdderTop.sv
// Top-level wiring; subtract selects a - b, otherwise a + b, three cycles from inValid to outValid
`timescale 1ns/1ps

module positAdderTop
(
    input  logic clk,
    input  logic rst,
    input  logic inValid,
    input  logic subtract,
    input  positPkg::positWord a,
    input  positPkg::positWord b,
    output logic outValid,
    output positPkg::positWord result
);

    positPkg::positWord opA, opB, encWord;
    logic sign1, sign2, nar1, nar2, zero1, zero2;
    logic signed [positPkg::regimeWidth-1:0] regime1, regime2;
    logic [positPkg::expWidth-1:0] exponent1, exponent2;
    logic [positPkg::mantWidth-1:0] mantissa1, mantissa2, sumMant, encMant;
    logic [positPkg::bodyWidth-1:0] body1, body2;
    logic signed [positPkg::scaleWidth-1:0] sumScale, encScale;
    logic sumSign, sumZero, encSign;

    positAddControl i_positAddControl
    (
        .clk(clk), .rst(rst), .inValid(inValid), .subtract(subtract), .a(a), .b(b),
        .opA(opA), .opB(opB),
        .nar1(nar1), .nar2(nar2), .zero1(zero1), .zero2(zero2),
        .sumMant(sumMant), .sumScale(sumScale), .sumSign(sumSign), .sumZero(sumZero),
        .encMant(encMant), .encScale(encScale), .encSign(encSign),
        .encWord(encWord), .outValid(outValid), .result(result)
    );

    // Operand decode, one per side
    positDecoder i_positDecoder1
    (
        .word(opA), .sign(sign1), .regime(regime1), .exponent(exponent1),
        .mantissa(mantissa1), .body(body1), .isNaR(nar1), .isZero(zero1)
    );

    positDecoder i_positDecoder2
    (
        .word(opB), .sign(sign2), .regime(regime2), .exponent(exponent2),
        .mantissa(mantissa2), .body(body2), .isNaR(nar2), .isZero(zero2)
    );

    positAddSub i_positAddSub
    (
        .clk(clk), .rst(rst), .sign1(sign1), .sign2(sign2),
        .regime1(regime1), .regime2(regime2), .exponent1(exponent1), .exponent2(exponent2),
        .mantissa1(mantissa1), .mantissa2(mantissa2), .body1(body1), .body2(body2),
        .sumMant(sumMant), .sumScale(sumScale), .sumSign(sumSign), .sumZero(sumZero)
    );

    positEncoder i_positEncoder
    (
        .sign(encSign), .scale(encScale), .mant(encMant), .word(encWord)
    );

endmodule

//--- positAdder_assertions.sv
// Bound into positAdderTop; checks assume no operation is offered while rst is high
`timescale 1ns/1ps

module positAdderAssertions
(
    input logic clk,
    input logic rst,
    input logic inValid,
    input positPkg::positWord a,
    input positPkg::positWord b,
    input logic outValid,
    input positPkg::positWord result
);

    logic narIn;

    // NaR on either side, negating NaR keeps NaR
    assign narIn = inValid
        && (a.value == positPkg::narPattern || b.value == positPkg::narPattern);

    // Output stage cleared by every reset edge
    resetClears: assert property (@(posedge clk) rst |=> !outValid && result.value == '0)
        else $error("outValid or result not cleared after a reset edge");

    // Set on the third edge, so visible one sample later
    latencyMatch: assert property (@(posedge clk) disable iff (rst)
        outValid == $past(inValid, positPkg::pipeDepth + 1))
        else $error("outValid does not follow inValid by the pipeline depth");

    narResult: assert property (@(posedge clk) disable iff (rst)
        $past(narIn, positPkg::pipeDepth + 1) |-> outValid && result.value == positPkg::narPattern)
        else $error("NaR operand did not give a NaR result");

endmodule

bind positAdderTop positAdderAssertions i_positAdderAssertions
(
    .clk(clk), .rst(rst), .inValid(inValid), .a(a), .b(b),
    .outValid(outValid), .result(result)
);

//--- tbPositAdder.sv
// Needs positAdderStim.txt in the run directory; one operation per cycle and results checked in order
`timescale 1ns/1ps

module tbPositAdder;

    logic clk;
    logic rst;
    logic inValid;
    logic subtract;
    positPkg::positWord a;
    positPkg::positWord b;
    logic outValid;
    positPkg::positWord result;

    // Vectors as read from the stim file
    int vecOp[$];
    logic [15:0] vecA[$];
    logic [15:0] vecB[$];
    logic [15:0] vecExp[$];

    // Operations in flight, oldest first
    logic [15:0] expectQueue[$];
    int dueQueue[$];
    string nameQueue[$];

    int cycleCount = 0;
    int checkCount = 0;
    int valueErrors = 0;
    int latencyErrors = 0;
    int otherErrors = 0;

    positAdderTop i_positAdderTop
    (
        .clk(clk), .rst(rst), .inValid(inValid), .subtract(subtract), .a(a), .b(b),
        .outValid(outValid), .result(result)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Rising edges seen so far
    always @(posedge clk)
        cycleCount <= cycleCount + 1;

    ////////////////////////////////////////////////////////////////////////////
    // Vector file and driver
    ////////////////////////////////////////////////////////////////////////////

    // Lines that do not scan as four hex fields are comments
    task automatic loadVectors(output bit opened);
        int fd;
        int fields;
        int op;
        logic [15:0] va, vb, ve;
        string line;
        fd = $fopen("positAdderStim.txt", "r");
        opened = (fd != 0);
        if (opened)
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                fields = $sscanf(line, "%h %h %h %h", op, va, vb, ve);
                if (fields == 4)
                begin
                    vecOp.push_back(op);
                    vecA.push_back(va);
                    vecB.push_back(vb);
                    vecExp.push_back(ve);
                end
            end
            $fclose(fd);
        end
    endtask

    // Op 2 is a bubble with inValid low
    task automatic driveOperation(input int idx);
        @(negedge clk);
        if (vecOp[idx] == 2)
            inValid = 1'b0;
        else
        begin
            inValid = 1'b1;
            subtract = (vecOp[idx] == 1);
            a.value = vecA[idx];
            b.value = vecB[idx];
            expectQueue.push_back(vecExp[idx]);
            // Sampled on the next edge, out after pipeDepth more edges
            dueQueue.push_back(cycleCount + 1 + positPkg::pipeDepth);
            nameQueue.push_back($sformatf("vector %0d %s %h %h", idx,
                subtract ? "sub" : "add", vecA[idx], vecB[idx]));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Result checker, on the falling edge where outputs are settled
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        logic [15:0] expected;
        int due;
        string name;
        if (!rst && outValid)
        begin
            assert (expectQueue.size() > 0)
            else
            begin
                $display("Error: outValid high at cycle %0d with nothing pending", cycleCount);
                otherErrors++;
            end
            if (expectQueue.size() > 0)
            begin
                expected = expectQueue.pop_front();
                due = dueQueue.pop_front();
                name = nameQueue.pop_front();
                checkCount++;
                assert (result.value === expected)
                else
                begin
                    $display("Fail %s expected %h actual %h", name, expected, result.value);
                    valueErrors++;
                end
                assert (cycleCount == due)
                else
                begin
                    $display("Error: %s came out at cycle %0d, not %0d", name, cycleCount, due);
                    latencyErrors++;
                end
            end
        end
    end

    initial
    begin
        bit opened;
        int waitCycles;
        rst = 1'b1;
        inValid = 1'b0;
        subtract = 1'b0;
        a = '0;
        b = '0;
        loadVectors(opened);
        if (!opened || vecOp.size() == 0)
        begin
            $display("Error: no vectors could be read from positAdderStim.txt");
            $display("TEST FAILED");
            $finish;
        end
        else
        begin
            repeat (16) @(negedge clk);
            rst = 1'b0;
            foreach (vecOp[i])
                driveOperation(i);
            @(negedge clk);
            inValid = 1'b0;
            // Drain, bounded at 50 cycles
            waitCycles = 0;
            while (expectQueue.size() > 0 && waitCycles < 50)
            begin
                @(negedge clk);
                waitCycles++;
            end
            if (expectQueue.size() > 0)
            begin
                $display("Error: %0d results never came out", expectQueue.size());
                otherErrors++;
            end
            $display("Checks %0d, value errors %0d, latency errors %0d, other errors %0d",
                checkCount, valueErrors, latencyErrors, otherErrors);
            if (valueErrors + latencyErrors + otherErrors == 0)
                $display("TEST PASSED");
            else
                $display("TEST FAILED");
            $finish;
        end
    end

endmodule

//--- positAdderStim.txt
# op a b expected, all hex posit16 es=1 words
# op 0 gives a + b, 1 gives a - b, 2 is an idle cycle whose other fields are ignored
0 4000 4000 5000
0 4000 5000 5800
0 4000 6000 6200
0 5000 5000 6000
0 c000 c000 b000
0 c000 b000 a800
0 7000 3000 7020
1 4800 4000 3000
1 4001 4000 0100
1 5800 5400 3000
1 4000 3800 2000
1 5800 5800 0000
0 4000 c000 0000
2 0000 0000 0000
0 5800 c000 5000
0 4000 a800 b000
1 c000 4000 b000
0 4000 00c0 4000
0 4001 00c0 4002
0 4000 00e0 4001
0 7f00 7400 7f00
0 7f01 7400 7f02
0 7f00 4000 7f00
0 7fff 7fff 7fff
0 8001 8001 8001
0 0001 0001 0002
1 0002 0001 0002
0 8000 4000 8000
1 4000 8000 8000
0 5800 0000 5800
0 0000 c000 c000
1 0000 5800 a800
1 4800 0000 4800

//--- tb.f
positPkg.sv
leadingBitDetector.sv
positDecoder.sv
positAddSub.sv
positEncoder.sv
positAddControl.sv
positAdderTop.sv
positAdder_assertions.sv
tbPositAdder.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tbPositAdder
FILELIST = tb.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(BUILD)
